/* hdl/dram_tge_pkg.sv */
package dram_tge_pkg;

    // one DRAM data word, nine 32-bit lanes
    typedef logic [287:0] dram_word_t;

    // one traffic-generator output word
    typedef logic [255:0] tge_word_t;

    typedef logic [24:0] dram_addr_t;  // DRAM word address

    // run-time configuration and count values
    typedef logic [31:0] cfg_t;

    // reader pacing states
    typedef enum logic [2:0] {
        RD_IDLE,
        RD_BURST,
        RD_BUBBLE,
        RD_PKT_WAIT,
        RD_DONE
    } reader_state_t;

endpackage

/* hdl/dram_burst_reader.sv */
`timescale 1ns/1ps

module dram_burst_reader
    import dram_tge_pkg::*;
#(
    parameter int FIFO_DEPTH    = 16,
    parameter int DRAM_MAX_ADDR = 64
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       en,
    input  cfg_t       dram_burst_size,
    input  cfg_t       wait_pkt,
    input  logic       fifo_pop,
    input  logic       pkt_done,
    output logic       dram_request,
    output dram_addr_t dram_addr,
    output logic       finish
);

    localparam int CW = $clog2(FIFO_DEPTH) + 1;

    reader_state_t state;

    cfg_t          burst_cnt;   // requests issued in the current burst
    cfg_t          bubble_cnt;
    cfg_t          wait_cnt;
    dram_addr_t    addr_cnt;
    logic [CW-1:0] credits;     // words requested but not yet popped

    cfg_t burst_len;
    cfg_t bubble_len;
    logic credit_ok;
    logic last_addr;
    logic burst_end;

    assign burst_len  = dram_burst_size << 3;  // 8 words per burst unit
    assign bubble_len = dram_burst_size << 1;  // 2 idle cycles per unit

    assign credit_ok = credits < CW'(FIFO_DEPTH);
    assign last_addr = addr_cnt == dram_addr_t'(DRAM_MAX_ADDR - 1);
    assign burst_end = (burst_cnt + 1) >= burst_len;

    // a request never waits on anything but the credit count once in a burst
    assign dram_request = (state == RD_BURST) && credit_ok;
    assign dram_addr    = addr_cnt;
    assign finish       = state == RD_DONE;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= '0;
        end else begin
            credits <= credits + CW'(dram_request) - CW'(fifo_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= RD_IDLE;
            burst_cnt  <= '0;
            bubble_cnt <= '0;
            wait_cnt   <= '0;
            addr_cnt   <= '0;
        end else begin
            if (dram_request) begin
                addr_cnt  <= addr_cnt + 1'b1;
                burst_cnt <= burst_end ? '0 : burst_cnt + 1;
            end
            case (state)
                RD_IDLE: begin
                    if (en) state <= RD_BURST;
                end
                RD_BURST: begin
                    if (dram_request && last_addr) begin
                        state <= RD_DONE;
                    end else if (pkt_done) begin
                        // current request still goes out, burst count resumes later
                        state    <= RD_PKT_WAIT;
                        wait_cnt <= '0;
                    end else if (dram_request && burst_end) begin
                        state      <= RD_BUBBLE;
                        bubble_cnt <= '0;
                    end
                end
                RD_BUBBLE: begin
                    if (pkt_done) begin  // packet wait replaces the bubble
                        state    <= RD_PKT_WAIT;
                        wait_cnt <= '0;
                    end else if ((bubble_cnt + 1) >= bubble_len) begin
                        state <= RD_BURST;
                    end else begin
                        bubble_cnt <= bubble_cnt + 1;
                    end
                end
                RD_PKT_WAIT: begin
                    if ((wait_cnt + 1) >= wait_pkt) state <= RD_BURST;
                    else wait_cnt <= wait_cnt + 1;
                end
                RD_DONE: ;  // held until reset
                default: state <= RD_IDLE;
            endcase
        end
    end

    // FIFO can only overflow if more words are outstanding than it holds
    assert property (@(posedge clk) disable iff (rst) credits <= CW'(FIFO_DEPTH))
        else $error("reader credit count above FIFO depth");

    // end of run has to stop requests at the last address
    assert property (@(posedge clk) disable iff (rst)
        dram_request |-> addr_cnt < dram_addr_t'(DRAM_MAX_ADDR))
        else $error("request past the last DRAM address");

endmodule

/* hdl/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo
    import dram_tge_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  dram_word_t wdata,
    input  logic       w_valid,
    input  logic       read_req,
    output dram_word_t rdata,
    output logic       r_valid,
    output logic       full,
    output logic       empty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    dram_word_t mem [0:FIFO_DEPTH-1];

    // top bit is the wrap flag
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        do_write;
    logic        do_read;

    assign empty = wr_ptr == rd_ptr;
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_write = w_valid && !full;
    assign do_read  = read_req && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            r_valid <= 1'b0;
        end else begin
            if (do_write) wr_ptr <= wr_ptr + 1'b1;
            if (do_read) rd_ptr <= rd_ptr + 1'b1;
            r_valid <= do_read;  // data lands one cycle after the pop
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) mem[wr_ptr[AW-1:0]] <= wdata;
        if (do_read) rdata <= mem[rd_ptr[AW-1:0]];
    end

    // the reader's credit count should make both of these impossible
    assert property (@(posedge clk) disable iff (rst) w_valid |-> !full)
        else $error("FIFO write while full");

    assert property (@(posedge clk) disable iff (rst) read_req |-> !empty)
        else $error("FIFO read while empty");

endmodule

/* hdl/word_gearbox.sv */
`timescale 1ns/1ps

module word_gearbox
    import dram_tge_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  dram_word_t fifo_rdata,
    input  logic       fifo_rvalid,
    input  logic       fifo_empty,
    output logic       fifo_pop,
    output tge_word_t  tge_data,
    output logic       tge_data_valid
);

    localparam int IN_W  = 288;
    localparam int OUT_W = 256;
    localparam int RES_W = IN_W + OUT_W - 1;  // 255 left over plus one full word

    // residue is packed from bit 0, bits at and above bit_cnt stay zero
    logic [RES_W-1:0] residue;
    logic [9:0]       bit_cnt;

    logic             emit;
    logic [9:0]       kept_cnt;   // bits left after this cycle's output
    logic [9:0]       next_cnt;
    logic [RES_W-1:0] kept;
    logic [RES_W-1:0] incoming;

    assign emit     = bit_cnt >= 10'(OUT_W);
    assign kept_cnt = emit ? bit_cnt - 10'(OUT_W) : bit_cnt;
    assign next_cnt = fifo_rvalid ? kept_cnt + 10'(IN_W) : kept_cnt;

    // a pop whose data arrives now is already counted in next_cnt
    assign fifo_pop = !fifo_empty && (next_cnt < 10'(OUT_W));

    assign kept     = emit ? residue >> OUT_W : residue;
    assign incoming = {{(RES_W - IN_W){1'b0}}, fifo_rdata} << kept_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            residue        <= '0;  // zero fill keeps the OR-merge clean
            bit_cnt        <= '0;
            tge_data_valid <= 1'b0;
        end else begin
            residue        <= fifo_rvalid ? (kept | incoming) : kept;
            bit_cnt        <= next_cnt;
            tge_data_valid <= emit;
        end
    end

    // lowest 256 bits leave first
    always_ff @(posedge clk) begin
        if (emit) tge_data <= residue[OUT_W-1:0];
    end

    assert property (@(posedge clk) disable iff (rst) bit_cnt <= 10'(RES_W))
        else $error("gearbox residue over %0d bits", RES_W);

endmodule

/* hdl/pkt_framer.sv */
`timescale 1ns/1ps

module pkt_framer
    import dram_tge_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  cfg_t tge_pkt_size,
    input  logic tge_data_valid,
    output logic tge_eof,
    output logic pkt_done
);

    cfg_t word_cnt;   // words already sent in the current packet
    logic last_word;

    // a size of 0 or 1 makes every word a packet of its own
    assign last_word = (word_cnt + 1) >= tge_pkt_size;

    assign tge_eof  = tge_data_valid && last_word;
    assign pkt_done = tge_eof;  // same cycle, goes back to the reader

    always_ff @(posedge clk) begin
        if (rst) begin
            word_cnt <= '0;
        end else if (tge_data_valid) begin
            if (last_word) word_cnt <= '0;
            else word_cnt <= word_cnt + 1;
        end
    end

endmodule

/* hdl/dram_tge.sv */
`timescale 1ns/1ps

module dram_tge
    import dram_tge_pkg::*;
#(
    parameter int FIFO_DEPTH    = 16,
    parameter int DRAM_MAX_ADDR = 64
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       en,
    input  cfg_t       dram_burst_size,
    input  cfg_t       tge_pkt_size,
    input  cfg_t       wait_pkt,
    input  dram_word_t dram_data,
    input  logic       dram_valid,
    output logic       dram_request,
    output dram_addr_t dram_addr,
    output tge_word_t  tge_data,
    output logic       tge_data_valid,
    output logic       tge_eof,
    output logic       finish
);

    dram_word_t fifo_rdata;
    logic       fifo_rvalid;
    logic       fifo_empty;
    logic       fifo_pop;
    logic       pkt_done;

    dram_burst_reader #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .DRAM_MAX_ADDR(DRAM_MAX_ADDR)
    ) u_reader (
        .clk            (clk),
        .rst            (rst),
        .en             (en),
        .dram_burst_size(dram_burst_size),
        .wait_pkt       (wait_pkt),
        .fifo_pop       (fifo_pop),    // returns one credit
        .pkt_done       (pkt_done),
        .dram_request   (dram_request),
        .dram_addr      (dram_addr),
        .finish         (finish)
    );

    // DRAM answers go straight into the FIFO, full is covered by credits
    sync_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk     (clk),
        .rst     (rst),
        .wdata   (dram_data),
        .w_valid (dram_valid),
        .read_req(fifo_pop),
        .rdata   (fifo_rdata),
        .r_valid (fifo_rvalid),
        .full    (),
        .empty   (fifo_empty)
    );

    word_gearbox u_gearbox (
        .clk           (clk),
        .rst           (rst),
        .fifo_rdata    (fifo_rdata),
        .fifo_rvalid   (fifo_rvalid),
        .fifo_empty    (fifo_empty),
        .fifo_pop      (fifo_pop),
        .tge_data      (tge_data),
        .tge_data_valid(tge_data_valid)
    );

    pkt_framer u_framer (
        .clk           (clk),
        .rst           (rst),
        .tge_pkt_size  (tge_pkt_size),
        .tge_data_valid(tge_data_valid),
        .tge_eof       (tge_eof),
        .pkt_done      (pkt_done)
    );

endmodule

/* tb/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 10
) (
    input  logic restart,  // starts a fresh reset pulse
    output logic clk,
    output logic rst
);

    int rst_cnt = 0;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // rst stays high for RST_CYCLES rising edges
    always @(posedge clk) begin
        if (restart) rst_cnt <= 0;
        else if (rst_cnt < RST_CYCLES) rst_cnt <= rst_cnt + 1;
    end

    assign rst = rst_cnt < RST_CYCLES;

endmodule

/* tb/tb_dram_tge.sv */
`timescale 1ns/1ps

module tb_dram_tge
    import dram_tge_pkg::*;
();

    localparam int DRAM_WORDS = 64;
    localparam int TGE_WORDS  = 72;  // 64 x 288 bits = 72 x 256 bits
    localparam int FIFO_DEPTH = 16;
    localparam int WAIT_PKT   = 12;
    localparam int MAX_LAT    = 6;
    localparam int MAX_BURST  = 2;
    localparam int N_RUNS     = 2;
    localparam int WATCHDOG_NS =
        N_RUNS * DRAM_WORDS * (MAX_LAT + 2 * MAX_BURST + WAIT_PKT) * 4 * 10 + 2000;
    localparam logic [31:0] LANE_MULT = 32'h9e37_79b9;

    logic       clk, rst, restart, en;
    cfg_t       dram_burst_size, tge_pkt_size, wait_pkt;
    dram_word_t dram_data;
    logic       dram_valid, dram_request;
    dram_addr_t dram_addr;
    tge_word_t  tge_data;
    logic       tge_data_valid, tge_eof, finish;

    // DRAM model state
    int         seed = 32'h5019;
    dram_addr_t req_q[$];
    int         due_q[$];  // cycle on which each queued word returns
    int         cyc = 0;
    int         last_due = 0;
    int         lat;
    int         due;

    // checker state
    dram_addr_t exp_addr;
    int         out_count = 0;
    int         run_len, prev_run, idle_len, quiet_left;
    logic       last_req_seen;

    clk_gen u_clk_gen (.restart(restart), .clk(clk), .rst(rst));

    dram_tge #(.FIFO_DEPTH(FIFO_DEPTH), .DRAM_MAX_ADDR(DRAM_WORDS)) u_dram_tge (.*);

    // nine 32-bit lanes, lane i is the address xor i times a constant
    function automatic dram_word_t dram_word_for(dram_addr_t a);
        dram_word_t d;
        for (int i = 0; i < 9; i++) d[i*32 +: 32] = 32'(a) ^ (32'(i) * LANE_MULT);
        return d;
    endfunction

    // DRAM words laid end to end from bit 0, cut into 256-bit slices
    function automatic tge_word_t expected_word(int idx);
        tge_word_t  w;
        dram_word_t d;
        int         g;
        for (int j = 0; j < 256; j++) begin
            g = idx * 256 + j;
            if (j == 0 || g % 288 == 0) d = dram_word_for(dram_addr_t'(g / 288));
            w[j] = d[g % 288];
        end
        return w;
    endfunction

    task automatic abort_with(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input tge_word_t got, input tge_word_t exp, input int idx);
        if (got !== exp)
            abort_with($sformatf("Error: %0d ns, output word %0d is %h, expected %h",
                                 $time, idx, got, exp));
    endtask

    task automatic check_addr(input dram_addr_t got, input dram_addr_t exp);
        if (got !== exp)
            abort_with($sformatf("Error: %0d ns, request address %0d, expected %0d",
                                 $time, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            abort_with($sformatf("Error: %0d ns, %s is %b, expected %b", $time, what, got, exp));
    endtask

    // requests are taken at the falling edge, answers go out 1 ns after the rising edge
    initial begin
        dram_valid = 1'b0;
        dram_data  = '0;
        forever begin
            @(posedge clk);
            #1;
            cyc        = cyc + 1;
            dram_valid = 1'b0;
            if (rst) begin
                req_q.delete();
                due_q.delete();
                last_due = 0;
            end else if (req_q.size() > 0 && due_q[0] <= cyc) begin
                dram_data  = dram_word_for(req_q.pop_front());
                dram_valid = 1'b1;
                void'(due_q.pop_front());
            end
            @(negedge clk);
            if (dram_request) begin
                lat = 1 + int'(($random(seed) & 32'h7fff_ffff) % MAX_LAT);
                due = cyc + lat;
                if (due <= last_due) due = last_due + 1;  // answers stay in order
                last_due = due;
                req_q.push_back(dram_addr);
                due_q.push_back(due);
            end
        end
    end

    always @(negedge clk) begin
        int burst_len;
        int bubble_len;
        burst_len  = int'(dram_burst_size) * 8;
        bubble_len = int'(dram_burst_size) * 2;
        if (rst) begin
            exp_addr      = '0;
            out_count     = 0;
            run_len       = 0;
            prev_run      = 0;
            idle_len      = 0;
            quiet_left    = 0;
            last_req_seen = 1'b0;
        end else begin
            check_flag(finish, last_req_seen, "finish");
            if (dram_request) begin
                if (last_req_seen) abort_with("a request was issued after the last address");
                check_addr(dram_addr, exp_addr);
                if (quiet_left > 0)
                    abort_with($sformatf("request at %0d ns inside the packet wait", $time));
                if (run_len == 0 && prev_run == burst_len && idle_len < bubble_len)
                    abort_with($sformatf("bubble of %0d cycles too short at %0d ns",
                                         idle_len, $time));
                run_len++;
                if (run_len > burst_len)
                    abort_with($sformatf("request run longer than a burst at %0d ns", $time));
                if (dram_addr == dram_addr_t'(DRAM_WORDS - 1)) last_req_seen = 1'b1;
                exp_addr++;
            end else begin
                if (run_len > 0) begin
                    prev_run = run_len;
                    run_len  = 0;
                    idle_len = 0;
                end
                idle_len++;
            end
            // an eof inside a running wait does not restart it
            if (quiet_left > 0) quiet_left--;
            else if (tge_eof) quiet_left = int'(wait_pkt);
            if (tge_data_valid) begin
                if (out_count >= TGE_WORDS) abort_with("more output words than expected");
                check_word(tge_data, expected_word(out_count), out_count);
                check_flag(tge_eof, ((out_count + 1) % int'(tge_pkt_size)) == 0, "tge_eof");
                out_count++;
            end else begin
                check_flag(tge_eof, 1'b0, "tge_eof");
            end
        end
    end

    task automatic run_config(input cfg_t burst, input cfg_t pkt);
        @(posedge clk);
        #1;
        restart         = 1'b1;
        en              = 1'b0;
        dram_burst_size = burst;
        tge_pkt_size    = pkt;
        wait_pkt        = cfg_t'(WAIT_PKT);
        @(posedge clk);
        #1;
        restart = 1'b0;
        wait (!rst);
        @(posedge clk);
        #1;
        en = 1'b1;
        wait (out_count == TGE_WORDS && finish);
        repeat (20) @(posedge clk);  // room for a stray extra word to show up
        $display("run with burst size %0d, packet size %0d complete", burst, pkt);
    endtask

    initial begin
        restart         = 1'b0;
        en              = 1'b0;
        dram_burst_size = 32'd1;
        tge_pkt_size    = 32'd9;
        wait_pkt        = cfg_t'(WAIT_PKT);
        run_config(32'd1, 32'd9);
        run_config(32'd2, 32'd5);
        $display("Testbench passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_with($sformatf("Timeout: the run did not end within %0d ns", WATCHDOG_NS));
    end

endmodule

/* dram_tge.f */
hdl/dram_tge_pkg.sv
hdl/dram_burst_reader.sv
hdl/sync_fifo.sv
hdl/word_gearbox.sv
hdl/pkt_framer.sv
hdl/dram_tge.sv
tb/clk_gen.sv
tb/tb_dram_tge.sv

/* Makefile */
# Verilator build and run of the dram_tge testbench

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_dram_tge -f dram_tge.f -Mdir obj_dir

run: compile
	./obj_dir/Vtb_dram_tge

clean:
	rm -rf obj_dir

.PHONY: compile run clean
